//--- core_types_pkg.sv
/*
 * Core type constants
 * Widths and fixed sizes shared by the whole front end
 */

package core_types_pkg;

	// ------------------------------------------------------------------------
	// Program counter

	// Byte address width
	localparam int PC_WIDTH = 32;

	// Reset PC of the core
	localparam logic [PC_WIDTH-1:0] INIT_PC = 32'h8000_0000;

	// ------------------------------------------------------------------------
	// Fetch and dequeue geometry

	// One RVC parcel
	localparam int HW_WIDTH = 16;

	// Halfwords in one fetch block (16 bytes)
	localparam int FETCH_2B = 8;

	// Slot index inside a fetch block
	localparam int FETCH_OFS_W = $clog2(FETCH_2B);

	// Counts of 0 to FETCH_2B halfwords
	localparam int FETCH_CNT_W = FETCH_OFS_W + 1;

	// Instructions handed to decode per cycle
	localparam int DEQ_WAYS = 4;

endpackage

//--- istream_pkg.sv
/*
 * Instruction stream types
 * Fetch block, ring entry and dequeue bundle layouts plus buffer sizing
 */

package istream_pkg;

	import core_types_pkg::*;

	// ------------------------------------------------------------------------
	// Buffer sizing

	localparam int ISTREAM_SETS = 8;
	localparam int ISTREAM_ENTRIES = ISTREAM_SETS * FETCH_2B;
	localparam int ISTREAM_PTR_W = $clog2(ISTREAM_ENTRIES);

	// Occupancy needs one more bit than a pointer (0 to 64)
	localparam int ISTREAM_CNT_W = ISTREAM_PTR_W + 1;

	// Three blocks of slack, two of them possibly in flight
	localparam int STALL_MARGIN = 3 * FETCH_2B;

	// ------------------------------------------------------------------------
	// Stream types

	typedef struct packed {
		logic [FETCH_2B-1:0] valid_mask;
		logic [FETCH_2B-1:0][HW_WIDTH-1:0] instr;
		logic [FETCH_2B-1:0] pred;
		logic [PC_WIDTH-1:0] after_pc;
	} fetch_block_t;

	typedef struct packed {
		logic [HW_WIDTH-1:0] instr;
		logic pred;
		logic [PC_WIDTH-1:0] pc;
	} hw_entry_t;

	// Halfword 1 only meaningful when uncompressed
	typedef struct packed {
		logic valid;
		logic uncompressed;
		logic [1:0][HW_WIDTH-1:0] instr;
		logic [1:0] pred;
		logic [PC_WIDTH-1:0] pc;
	} way_t;

	typedef struct packed {
		logic valid;
		way_t [DEQ_WAYS-1:0] ways;
	} deq_bundle_t;

	typedef enum logic {
		IS_STREAM = 1'b0,
		IS_RESTARTED = 1'b1
	} istream_state_e;

endpackage

//--- istream_enq.sv
/*
 * Instruction stream enqueue
 * Trims the first block after a restart and packs live halfwords for the ring
 */

`timescale 1ns/1ns

module istream_enq
	import core_types_pkg::*;
	import istream_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input logic valid_SENQ,
	input fetch_block_t fetch_SENQ,
	input logic restart,
	input logic [PC_WIDTH-1:0] restart_pc,
	output logic wr_en,
	output hw_entry_t [FETCH_2B-1:0] wr_entries,
	output logic [FETCH_CNT_W-1:0] wr_count
);

	istream_state_e state;
	logic [FETCH_OFS_W-1:0] restart_ofs;
	logic [PC_WIDTH-1:0] block_base;
	logic [FETCH_2B-1:0] keep_mask;
	hw_entry_t [FETCH_2B-1:0] slot_entries;

	// Restart tracking
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= IS_STREAM;
			restart_ofs <= INIT_PC[FETCH_OFS_W:1];
		end else if (restart) begin
			state <= IS_RESTARTED;
			restart_ofs <= restart_pc[FETCH_OFS_W:1];
		end else if (valid_SENQ && state == IS_RESTARTED) begin
			state <= IS_STREAM;
		end
	end

	// after_pc points just past the 16-byte block
	always_comb begin
		block_base = fetch_SENQ.after_pc - PC_WIDTH'(2 * FETCH_2B);
		for (int i = 0; i < FETCH_2B; i++) begin
			slot_entries[i].instr = fetch_SENQ.instr[i];
			slot_entries[i].pred = fetch_SENQ.pred[i];
			slot_entries[i].pc = block_base + PC_WIDTH'(2 * i);
		end
	end

	// Drop halfwords that sit below the restart target
	always_comb begin
		keep_mask = fetch_SENQ.valid_mask;
		if (state == IS_RESTARTED) begin
			for (int i = 0; i < FETCH_2B; i++) begin
				if (FETCH_OFS_W'(i) < restart_ofs) begin
					keep_mask[i] = 1'b0;
				end
			end
		end
	end

	// Compact surviving slots toward slot 0, keeping their order
	always_comb begin
		logic [FETCH_CNT_W-1:0] cnt;
		cnt = '0;
		wr_entries = '0;
		for (int i = 0; i < FETCH_2B; i++) begin
			if (keep_mask[i]) begin
				wr_entries[cnt[FETCH_OFS_W-1:0]] = slot_entries[i];
				cnt = cnt + 1'b1;
			end
		end
		wr_count = cnt;
		wr_en = valid_SENQ && !restart && (cnt != '0);
	end

endmodule

//--- istream_buf.sv
/*
 * Instruction stream ring buffer
 * Holds halfword entries between enqueue and dequeue, with flush and fetch stall
 */

`timescale 1ns/1ns

module istream_buf
	import core_types_pkg::*;
	import istream_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input logic wr_en,
	input hw_entry_t [FETCH_2B-1:0] wr_entries,
	input logic [FETCH_CNT_W-1:0] wr_count,
	input logic restart,
	input logic stall_SDEQ,
	input logic [FETCH_CNT_W-1:0] pop_count,
	output hw_entry_t [FETCH_2B-1:0] head_entries,
	output logic [FETCH_CNT_W-1:0] head_count,
	output logic stall_SENQ
);

	hw_entry_t ring [ISTREAM_ENTRIES];

	logic [ISTREAM_PTR_W-1:0] head_ptr;
	logic [ISTREAM_PTR_W-1:0] tail_ptr;
	logic [ISTREAM_CNT_W-1:0] occupancy;
	logic [ISTREAM_CNT_W-1:0] free_count;
	logic [FETCH_CNT_W-1:0] push_cnt;
	logic [FETCH_CNT_W-1:0] pop_cnt;

	// ------------------------------------------------------------------------
	// Pointer and occupancy update

	assign push_cnt = wr_en ? wr_count : '0;
	assign pop_cnt = stall_SDEQ ? '0 : pop_count;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			occupancy <= '0;
		end else if (restart) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			occupancy <= '0;
		end else begin
			tail_ptr <= tail_ptr + ISTREAM_PTR_W'(push_cnt);
			head_ptr <= head_ptr + ISTREAM_PTR_W'(pop_cnt);
			occupancy <= occupancy + ISTREAM_CNT_W'(push_cnt) - ISTREAM_CNT_W'(pop_cnt);
		end
	end

	// ------------------------------------------------------------------------
	// Entry storage

	// Pointer sum wraps at the ring size
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			for (int i = 0; i < FETCH_2B; i++) begin
				if (FETCH_CNT_W'(i) < wr_count) begin
					ring[tail_ptr + ISTREAM_PTR_W'(i)] <= wr_entries[i];
				end
			end
		end
	end

	// Head window, empty slots read as zero
	always_comb begin
		if (occupancy > ISTREAM_CNT_W'(FETCH_2B)) begin
			head_count = FETCH_CNT_W'(FETCH_2B);
		end else begin
			head_count = occupancy[FETCH_CNT_W-1:0];
		end
		for (int i = 0; i < FETCH_2B; i++) begin
			if (FETCH_CNT_W'(i) < head_count) begin
				head_entries[i] = ring[head_ptr + ISTREAM_PTR_W'(i)];
			end else begin
				head_entries[i] = '0;
			end
		end
	end

	assign free_count = ISTREAM_CNT_W'(ISTREAM_ENTRIES) - occupancy;
	assign stall_SENQ = free_count < ISTREAM_CNT_W'(STALL_MARGIN);

	// ------------------------------------------------------------------------
	// Checks

	// Blocks still in flight when the stall rises must fit
	a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
		wr_en |-> (ISTREAM_CNT_W'(wr_count) <= free_count));

	// Dequeue never consumes past the head window
	a_pop_in_window: assert property (@(posedge CLK) disable iff (!nRST)
		pop_count <= head_count);

endmodule

//--- istream_deq.sv
/*
 * Instruction stream dequeue
 * Splits the head halfwords into up to four in-order instructions
 */

`timescale 1ns/1ns

module istream_deq
	import core_types_pkg::*;
	import istream_pkg::*;
(
	input hw_entry_t [FETCH_2B-1:0] head_entries,
	input logic [FETCH_CNT_W-1:0] head_count,
	output deq_bundle_t deq_SDEQ,
	output logic [FETCH_CNT_W-1:0] pop_count
);

	// Walk the head window one way at a time
	always_comb begin
		logic [FETCH_CNT_W-1:0] pos;
		logic [FETCH_CNT_W-1:0] next_pos;
		logic stop;
		logic is_long;
		hw_entry_t first_hw;
		hw_entry_t second_hw;

		deq_SDEQ = '0;
		pos = '0;
		next_pos = '0;
		stop = 1'b0;
		is_long = 1'b0;
		first_hw = '0;
		second_hw = '0;

		for (int w = 0; w < DEQ_WAYS; w++) begin
			if (!stop && pos < head_count) begin
				first_hw = head_entries[pos[FETCH_OFS_W-1:0]];
				// Low bits 11 mark a 32-bit instruction
				is_long = (first_hw.instr[1:0] == 2'b11);
				next_pos = pos + 1'b1;

				if (is_long && next_pos >= head_count) begin
					// Second half not here yet
					stop = 1'b1;
				end else begin
					deq_SDEQ.ways[w].valid = 1'b1;
					deq_SDEQ.ways[w].uncompressed = is_long;
					deq_SDEQ.ways[w].pc = first_hw.pc;
					deq_SDEQ.ways[w].instr[0] = first_hw.instr;
					deq_SDEQ.ways[w].pred[0] = first_hw.pred;
					if (is_long) begin
						second_hw = head_entries[next_pos[FETCH_OFS_W-1:0]];
						deq_SDEQ.ways[w].instr[1] = second_hw.instr;
						deq_SDEQ.ways[w].pred[1] = second_hw.pred;
						next_pos = next_pos + 1'b1;
					end
					pos = next_pos;
				end
			end else begin
				stop = 1'b1;
			end
		end

		pop_count = pos;
		deq_SDEQ.valid = deq_SDEQ.ways[0].valid;
	end

	// No hole in the bundle
	always_comb begin
		for (int k = 1; k < DEQ_WAYS; k++) begin
			a_way_order: assert (!deq_SDEQ.ways[k].valid || deq_SDEQ.ways[k-1].valid);
		end
	end

endmodule

//--- istream_wrapper.sv
/*
 * Instruction stream top
 * Registers every boundary signal around enqueue, ring buffer and dequeue
 */

`timescale 1ns/1ns

module istream_wrapper
	import core_types_pkg::*;
	import istream_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input logic next_valid_SENQ,
	input fetch_block_t next_fetch,
	output logic last_stall_SENQ,
	output deq_bundle_t last_deq_SDEQ,
	input logic next_stall_SDEQ,
	input logic next_restart,
	input logic [PC_WIDTH-1:0] next_restart_pc
);

	// ------------------------------------------------------------------------
	// Registered boundary

	logic valid_SENQ;
	fetch_block_t fetch_SENQ;
	logic stall_SENQ;
	deq_bundle_t deq_SDEQ;
	logic stall_SDEQ;
	logic restart;
	logic [PC_WIDTH-1:0] restart_pc;

	// Internal paths
	logic wr_en;
	hw_entry_t [FETCH_2B-1:0] wr_entries;
	logic [FETCH_CNT_W-1:0] wr_count;
	hw_entry_t [FETCH_2B-1:0] head_entries;
	logic [FETCH_CNT_W-1:0] head_count;
	logic [FETCH_CNT_W-1:0] pop_count;

	// ------------------------------------------------------------------------
	// Blocks

	istream_enq i_istream_enq (
		.CLK(CLK),
		.nRST(nRST),
		.valid_SENQ(valid_SENQ),
		.fetch_SENQ(fetch_SENQ),
		.restart(restart),
		.restart_pc(restart_pc),
		.wr_en(wr_en),
		.wr_entries(wr_entries),
		.wr_count(wr_count)
	);

	istream_buf i_istream_buf (
		.CLK(CLK),
		.nRST(nRST),
		.wr_en(wr_en),
		.wr_entries(wr_entries),
		.wr_count(wr_count),
		.restart(restart),
		.stall_SDEQ(stall_SDEQ),
		.pop_count(pop_count),
		.head_entries(head_entries),
		.head_count(head_count),
		.stall_SENQ(stall_SENQ)
	);

	istream_deq i_istream_deq (
		.head_entries(head_entries),
		.head_count(head_count),
		.deq_SDEQ(deq_SDEQ),
		.pop_count(pop_count)
	);

	// ------------------------------------------------------------------------
	// Boundary registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_SENQ <= 1'b0;
			fetch_SENQ <= '0;
			last_stall_SENQ <= 1'b0;
			last_deq_SDEQ <= '0;
			stall_SDEQ <= 1'b0;
			restart <= 1'b0;
			restart_pc <= '0;
		end else begin
			// Enqueue side
			valid_SENQ <= next_valid_SENQ;
			fetch_SENQ <= next_fetch;
			last_stall_SENQ <= stall_SENQ;
			// Dequeue side
			last_deq_SDEQ <= deq_SDEQ;
			stall_SDEQ <= next_stall_SDEQ;
			// Control
			restart <= next_restart;
			restart_pc <= next_restart_pc;
		end
	end

endmodule

//--- tb_istream.sv
/*
 * Instruction stream testbench
 * Feeds fetch blocks from the stimulus file and checks every consumed instruction
 */

`timescale 1ns/1ns

module tb_istream
	import core_types_pkg::*;
	import istream_pkg::*;
();

	localparam int WAIT_LIMIT = 2000;

	// Cycles allowed for a stalled fill to raise the fetch stall
	localparam int FILL_LIMIT = 100;

	// Output stall modes
	localparam int STALL_NONE = 0;
	localparam int STALL_RANDOM = 1;
	localparam int STALL_HOLD = 2;
	localparam int STALL_FILL = 3;

	logic CLK;
	logic nRST;
	logic next_valid_SENQ;
	fetch_block_t next_fetch;
	logic last_stall_SENQ;
	deq_bundle_t last_deq_SDEQ;
	logic next_stall_SDEQ;
	logic next_restart;
	logic [PC_WIDTH-1:0] next_restart_pc;

	// Command list and expected stream
	byte cmd_kind [$];
	fetch_block_t cmd_blk [$];
	logic [31:0] cmd_arg [$];
	int cmd_ecount [$];
	way_t exp_q [$];

	int exp_idx;
	int stall_mode;
	int seed;
	logic stall_cur;
	logic stall_prev;
	logic checking;
	int fill_cnt;

	istream_wrapper i_istream_wrapper (
		.CLK(CLK),
		.nRST(nRST),
		.next_valid_SENQ(next_valid_SENQ),
		.next_fetch(next_fetch),
		.last_stall_SENQ(last_stall_SENQ),
		.last_deq_SDEQ(last_deq_SDEQ),
		.next_stall_SDEQ(next_stall_SDEQ),
		.next_restart(next_restart),
		.next_restart_pc(next_restart_pc)
	);

	always #5 CLK = ~CLK;

	// ------------------------------------------------------------------------
	// Failure reporting and compare tasks

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_way(input way_t actual, input way_t expected);
		if (actual !== expected) begin
			$display("Fail last_deq_SDEQ way at pc %h: got %h, expected %h",
				expected.pc, actual, expected);
			abort_run("Dequeued instruction does not match");
		end
	endtask

	task automatic check_stall(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			$display("Fail %s: got %h, expected %h", name, actual, expected);
			abort_run("Status bit does not match");
		end
	endtask

	task automatic wait_for_matched(input int target);
		int cnt;
		cnt = 0;
		while (exp_idx < target) begin
			@(negedge CLK);
			cnt++;
			if (cnt > WAIT_LIMIT) begin
				abort_run("Timed out waiting for the expected instructions");
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Output monitor and stall driver

	// A bundle after edge e counts when the stall seen at edge e-1 was low
	always @(negedge CLK) begin
		if (nRST && checking) begin
			if (!stall_prev && last_deq_SDEQ.valid) begin
				for (int w = 0; w < DEQ_WAYS; w++) begin
					if (last_deq_SDEQ.ways[w].valid) begin
						if (exp_idx >= exp_q.size()) begin
							abort_run("More instructions came out than expected");
						end
						check_way(last_deq_SDEQ.ways[w], exp_q[exp_idx]);
						exp_idx++;
					end
				end
			end
			if (stall_mode == STALL_FILL) begin
				if (last_stall_SENQ) begin
					stall_mode = STALL_NONE;
				end else begin
					fill_cnt++;
					if (fill_cnt > FILL_LIMIT) begin
						abort_run("Filling the ring never raised last_stall_SENQ");
					end
				end
			end
			stall_prev = stall_cur;
			case (stall_mode)
				STALL_RANDOM: stall_cur = 1'($random(seed));
				STALL_HOLD: stall_cur = 1'b1;
				STALL_FILL: stall_cur = 1'b1;
				default: stall_cur = 1'b0;
			endcase
			next_stall_SDEQ = stall_cur;
		end
	end

	// ------------------------------------------------------------------------
	// Main sequence

	initial begin
		int fd;
		int n;
		int cnt;
		string line;
		byte tag;
		logic [7:0] mask;
		logic [7:0] pred;
		logic [15:0] h [8];
		logic [31:0] apc;
		logic [31:0] arg;
		logic u;
		logic [15:0] e0;
		logic [15:0] e1;
		logic [1:0] p2;
		fetch_block_t blk;
		way_t ew;

		CLK = 1'b0;
		nRST = 1'b0;
		next_valid_SENQ = 1'b0;
		next_fetch = '0;
		next_stall_SDEQ = 1'b0;
		next_restart = 1'b0;
		next_restart_pc = '0;
		exp_idx = 0;
		stall_mode = STALL_NONE;
		seed = 32'h8870_4cca;
		stall_cur = 1'b0;
		stall_prev = 1'b0;
		checking = 1'b0;
		fill_cnt = 0;

		fd = $fopen("istream_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open istream_stimulus.txt");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n <= 1) continue;
			tag = line[0];
			case (tag)
				"B": begin
					n = $sscanf(line, "B %h %h %h %h %h %h %h %h %h %h %h", mask,
						h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7], pred, apc);
					if (n != 11) abort_run("Malformed block line in the data file");
					blk.valid_mask = mask;
					for (int i = 0; i < FETCH_2B; i++) begin
						blk.instr[i] = h[i];
					end
					blk.pred = pred;
					blk.after_pc = apc;
					cmd_kind.push_back(tag);
					cmd_blk.push_back(blk);
					cmd_arg.push_back('0);
					cmd_ecount.push_back(exp_q.size());
				end
				"S", "R": begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h", arg);
					if (n != 1) abort_run("Malformed stall or restart line in the data file");
					cmd_kind.push_back(tag);
					cmd_blk.push_back('0);
					cmd_arg.push_back(arg);
					cmd_ecount.push_back(exp_q.size());
				end
				"E": begin
					n = $sscanf(line, "E %h %h %h %h %h", apc, u, e0, e1, p2);
					if (n != 5) abort_run("Malformed expected line in the data file");
					ew = '0;
					ew.valid = 1'b1;
					ew.uncompressed = u;
					ew.instr[0] = e0;
					ew.instr[1] = e1;
					ew.pred = p2;
					ew.pc = apc;
					exp_q.push_back(ew);
				end
				"#": ;
				default: abort_run("Unknown line type in the data file");
			endcase
		end
		$fclose(fd);

		repeat (8) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		// Idle stream before any block
		repeat (10) begin
			@(negedge CLK);
			check_stall(last_stall_SENQ, 1'b0, "last_stall_SENQ");
			check_stall(last_deq_SDEQ.valid, 1'b0, "last_deq_SDEQ.valid");
		end
		checking = 1'b1;

		for (int i = 0; i < cmd_kind.size(); i++) begin
			case (cmd_kind[i])
				"B": begin
					cnt = 0;
					while (last_stall_SENQ) begin
						@(negedge CLK);
						cnt++;
						if (cnt > WAIT_LIMIT) abort_run("Fetch stall never dropped");
					end
					next_valid_SENQ = 1'b1;
					next_fetch = cmd_blk[i];
					@(negedge CLK);
					next_valid_SENQ = 1'b0;
				end
				"S": begin
					wait_for_matched(cmd_ecount[i]);
					fill_cnt = 0;
					stall_mode = cmd_arg[i];
				end
				default: begin
					wait_for_matched(cmd_ecount[i]);
					// Let the last block reach the ring first
					repeat (3) @(negedge CLK);
					next_restart = 1'b1;
					next_restart_pc = cmd_arg[i];
					@(negedge CLK);
					next_restart = 1'b0;
				end
			endcase
		end

		wait_for_matched(exp_q.size());
		repeat (4) @(negedge CLK);
		if (!last_deq_SDEQ.valid) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run("Stream did not end empty");
		end
	end

endmodule

//--- istream_stimulus.txt
# B mask hw0..hw7 pred after_pc | S stall_mode (0 none 1 random 2 hold 3 fill) | R restart_pc
# E pc uncompressed hw0 hw1 pred
B ff 0100 0104 0108 010c 0110 0114 0118 011c 05 80000010
E 80000000 0 0100 0000 1
E 80000002 0 0104 0000 0
E 80000004 0 0108 0000 1
E 80000006 0 010c 0000 0
E 80000008 0 0110 0000 0
E 8000000a 0 0114 0000 0
E 8000000c 0 0118 0000 0
E 8000000e 0 011c 0000 0
B ff 0203 0204 0208 020f 0210 0214 0218 021b 80 80000020
E 80000010 1 0203 0204 0
E 80000014 0 0208 0000 0
E 80000016 1 020f 0210 0
E 8000001a 0 0214 0000 0
E 8000001c 0 0218 0000 0
E 8000001e 1 021b 0300 3
B 03 0300 0304 0000 0000 0000 0000 0000 0000 01 80000030
E 80000022 0 0304 0000 0
S 1
B ff 0403 0404 0407 0408 040b 040c 040f 0410 0c 80000040
E 80000030 1 0403 0404 0
E 80000034 1 0407 0408 3
E 80000038 1 040b 040c 0
E 8000003c 1 040f 0410 0
B ff 0503 0504 0507 0508 050b 050c 050f 0510 00 80000050
E 80000040 1 0503 0504 0
E 80000044 1 0507 0508 0
E 80000048 1 050b 050c 0
E 8000004c 1 050f 0510 0
S 3
B ff 0603 0604 0607 0608 060b 060c 060f 0610 00 80000060
B ff 0703 0704 0707 0708 070b 070c 070f 0710 00 80000070
B ff 0803 0804 0807 0808 080b 080c 080f 0810 00 80000080
B ff 0903 0904 0907 0908 090b 090c 090f 0910 00 80000090
B ff 0a03 0a04 0a07 0a08 0a0b 0a0c 0a0f 0a10 00 800000a0
B ff 0b03 0b04 0b07 0b08 0b0b 0b0c 0b0f 0b10 00 800000b0
E 80000050 1 0603 0604 0
E 80000054 1 0607 0608 0
E 80000058 1 060b 060c 0
E 8000005c 1 060f 0610 0
E 80000060 1 0703 0704 0
E 80000064 1 0707 0708 0
E 80000068 1 070b 070c 0
E 8000006c 1 070f 0710 0
E 80000070 1 0803 0804 0
E 80000074 1 0807 0808 0
E 80000078 1 080b 080c 0
E 8000007c 1 080f 0810 0
E 80000080 1 0903 0904 0
E 80000084 1 0907 0908 0
E 80000088 1 090b 090c 0
E 8000008c 1 090f 0910 0
E 80000090 1 0a03 0a04 0
E 80000094 1 0a07 0a08 0
E 80000098 1 0a0b 0a0c 0
E 8000009c 1 0a0f 0a10 0
E 800000a0 1 0b03 0b04 0
E 800000a4 1 0b07 0b08 0
E 800000a8 1 0b0b 0b0c 0
E 800000ac 1 0b0f 0b10 0
S 2
B ff 0e00 0e04 0e08 0e0c 0e10 0e14 0e18 0e1c 00 800000c0
R 80000106
S 0
B ff 0f00 0f04 0f08 0f0c 0f10 0f14 0f18 0f1c 00 80000110
E 80000106 0 0f0c 0000 0
E 80000108 0 0f10 0000 0
E 8000010a 0 0f14 0000 0
E 8000010c 0 0f18 0000 0
E 8000010e 0 0f1c 0000 0

//--- src.f
core_types_pkg.sv
istream_pkg.sv
istream_enq.sv
istream_buf.sv
istream_deq.sv
istream_wrapper.sv
tb_istream.sv

//--- Makefile
# Verilator build for the instruction stream testbench

TOP = tb_istream

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
